//--- Bender.yml
package:
  name: conn_ctx_mem

dependencies: {}

sources:
  - files:
      - conn_ctx_pkg.sv
      - conn_req_arbiter.sv
      - rci_sci_table.sv
      - pu_tag_fifo.sv
      - conn_ctx_store.sv
      - conn_ctx_mem.sv
  - target: test
    files:
      - tb_conn_ctx_mem.sv

//--- conn_ctx_mem.sv
// Top level of the connection-context read path: arbiter, translation table, tag FIFO and store
module conn_ctx_mem
	import conn_ctx_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic [num_pu-1:0] io_req,
	input io_cmd_t io_cmd [num_pu],

	input logic table_wr,
	input table_wr_t table_data,

	input logic reg_sel,
	input reg_req_t reg_req,
	output logic reg_ack,
	output ctx_data_t reg_rdata,

	output logic [num_pu-1:0] io_ack,
	output ctx_data_t io_ack_data [num_pu]
);

	logic gnt;
	pu_id_t gnt_pu;
	rci_t gnt_rci;

	logic rd_q;
	pu_id_t rd_pu_q;
	ofs_t rd_ofs_q;

	sci_t sci_q;
	ctx_rd_t ctx_rd;

	pu_id_t head_pu;
	logic app_ack;

	conn_req_arbiter i_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.io_req(io_req),
		.io_cmd(io_cmd),
		.gnt(gnt),
		.gnt_pu(gnt_pu),
		.gnt_rci(gnt_rci),
		.rd_q(rd_q),
		.rd_pu_q(rd_pu_q),
		.rd_ofs_q(rd_ofs_q)
	);

	rci_sci_table i_table (
		.clk(clk),
		.table_wr(table_wr),
		.table_data(table_data),
		.raddr(gnt_rci),
		.sci_q(sci_q)
	);

	// SCI from the table lines up with the registered offset
	assign ctx_rd.pu = rd_pu_q;
	assign ctx_rd.addr = {sci_q, rd_ofs_q};

	pu_tag_fifo #(
		.tag_t(pu_id_t)
	) i_tag_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(gnt),
		.din(gnt_pu),
		.pop(app_ack),
		.dout(head_pu)
	);

	conn_ctx_store i_store (
		.clk(clk),
		.rst_n(rst_n),
		.app_rd(rd_q),
		.app_addr(ctx_rd.addr),
		.head_pu(head_pu),
		.reg_sel(reg_sel),
		.reg_req(reg_req),
		.reg_ack(reg_ack),
		.reg_rdata(reg_rdata),
		.app_ack(app_ack),
		.io_ack(io_ack),
		.io_ack_data(io_ack_data)
	);

endmodule

//--- conn_ctx_pkg.sv
// Sizes, region code, address fields and packed structs of the connection-context subsystem
package conn_ctx_pkg;

	localparam int num_pu = 4;
	localparam int pu_id_nbits = 2;

	localparam int rci_nbits = 8;
	localparam int sci_nbits = 6;
	localparam int ofs_nbits = 4;
	localparam int ctx_addr_nbits = sci_nbits + ofs_nbits;
	localparam int ctx_width = 32;
	localparam int region_nbits = 4;

	localparam int table_depth = 2 ** rci_nbits;
	localparam int ctx_depth = 2 ** ctx_addr_nbits;

	// Reads in flight never exceed 3
	localparam int tag_fifo_depth = 4;
	localparam int tag_ptr_nbits = 2;

	typedef logic [pu_id_nbits-1:0] pu_id_t;
	typedef logic [rci_nbits-1:0] rci_t;
	typedef logic [sci_nbits-1:0] sci_t;
	typedef logic [ofs_nbits-1:0] ofs_t;
	typedef logic [ctx_addr_nbits-1:0] ctx_addr_t;
	typedef logic [ctx_width-1:0] ctx_data_t;

	localparam logic [region_nbits-1:0] region_ctx = 4'd3;

	typedef struct packed {
		logic [region_nbits-1:0] region;
		rci_t rci;
		ofs_t ofs;
	} io_cmd_t;

	typedef struct packed {
		rci_t rci;
		sci_t sci;
	} table_wr_t;

	typedef struct packed {
		logic rd;
		logic wr;
		ctx_addr_t addr;
		ctx_data_t wdata;
	} reg_req_t;

	// Application read towards the store, SCI in the upper address bits
	typedef struct packed {
		pu_id_t pu;
		ctx_addr_t addr;
	} ctx_rd_t;

endpackage

//--- conn_ctx_store.sv
// Context memory with host register port, application read port and per-PU response routing
module conn_ctx_store
	import conn_ctx_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic app_rd,
	input ctx_addr_t app_addr,
	input pu_id_t head_pu,

	input logic reg_sel,
	input reg_req_t reg_req,
	output logic reg_ack,
	output ctx_data_t reg_rdata,

	output logic app_ack,
	output logic [num_pu-1:0] io_ack,
	output ctx_data_t io_ack_data [num_pu]
);

	ctx_data_t mem [ctx_depth];

	logic host_pend;
	reg_req_t host_q;
	logic host_go;
	ctx_data_t app_rdata;

	// Host access waits for a cycle with no application read
	assign host_go = host_pend && !app_rd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			host_pend <= 1'b0;
			reg_ack <= 1'b0;
		end else begin
			if (reg_sel && (reg_req.rd || reg_req.wr))
				host_pend <= 1'b1;
			else if (host_go)
				host_pend <= 1'b0;
			reg_ack <= host_go;
		end
	end

	always_ff @(posedge clk) begin
		if (reg_sel && (reg_req.rd || reg_req.wr))
			host_q <= reg_req;
	end

	// Single port, the application read has priority
	always_ff @(posedge clk) begin
		if (app_rd) begin
			app_rdata <= mem[app_addr];
		end else if (host_go) begin
			if (host_q.wr)
				mem[host_q.addr] <= host_q.wdata;
			else
				reg_rdata <= mem[host_q.addr];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			app_ack <= 1'b0;
		else
			app_ack <= app_rd;
	end

	// Response goes to the PU at the head of the tag FIFO, other lanes stay zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			io_ack <= '0;
			for (int i = 0; i < num_pu; i++) begin
				io_ack_data[i] <= '0;
			end
		end else begin
			for (int i = 0; i < num_pu; i++) begin
				io_ack[i] <= app_ack && (head_pu == pu_id_t'(i));
				if (app_ack && (head_pu == pu_id_t'(i)))
					io_ack_data[i] <= app_rdata;
				else
					io_ack_data[i] <= '0;
			end
		end
	end

endmodule

//--- conn_req_arbiter.sv
// PU command capture, pending flags and round-robin grant with a registered read stage
module conn_req_arbiter
	import conn_ctx_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic [num_pu-1:0] io_req,
	input io_cmd_t io_cmd [num_pu],

	output logic gnt,
	output pu_id_t gnt_pu,
	output rci_t gnt_rci,

	output logic rd_q,
	output pu_id_t rd_pu_q,
	output ofs_t rd_ofs_q
);

	logic [num_pu-1:0] pend;
	logic [num_pu-1:0] take;
	logic [num_pu-1:0] gnt_vec;
	pu_id_t ptr;
	io_cmd_t cmd_q [num_pu];

	// Only commands aimed at the context region are kept
	always_comb begin
		for (int i = 0; i < num_pu; i++) begin
			take[i] = io_req[i] && (io_cmd[i].region == region_ctx) && !pend[i];
		end
	end

	// First pending PU at or after the pointer
	always_comb begin
		pu_id_t idx;
		gnt = 1'b0;
		gnt_pu = ptr;
		for (int i = 0; i < num_pu; i++) begin
			idx = ptr + pu_id_t'(i);
			if (!gnt && pend[idx]) begin
				gnt = 1'b1;
				gnt_pu = idx;
			end
		end
	end

	always_comb begin
		gnt_vec = '0;
		if (gnt)
			gnt_vec[gnt_pu] = 1'b1;
	end

	assign gnt_rci = cmd_q[gnt_pu].rci;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend <= '0;
			ptr <= '0;
			rd_q <= 1'b0;
		end else begin
			pend <= (pend & ~gnt_vec) | take;
			if (gnt)
				ptr <= gnt_pu + 1'b1;
			rd_q <= gnt;
		end
	end

	// Captured commands and the offset that travels alongside the table lookup
	always_ff @(posedge clk) begin
		for (int i = 0; i < num_pu; i++) begin
			if (take[i])
				cmd_q[i] <= io_cmd[i];
		end
		rd_pu_q <= gnt_pu;
		rd_ofs_q <= cmd_q[gnt_pu].ofs;
	end

endmodule

//--- pu_tag_fifo.sv
// Four-entry show-ahead FIFO for the tag of each read in flight
module pu_tag_fifo
	import conn_ctx_pkg::*;
#(
	parameter type tag_t = logic [1:0]
) (
	input logic clk,
	input logic rst_n,

	input logic push,
	input tag_t din,

	input logic pop,
	output tag_t dout
);

	tag_t mem [tag_fifo_depth];

	logic [tag_ptr_nbits-1:0] wr_ptr;
	logic [tag_ptr_nbits-1:0] rd_ptr;
	logic [tag_ptr_nbits:0] count;

	logic do_push;
	logic do_pop;

	assign do_push = push && (count != (tag_ptr_nbits + 1)'(tag_fifo_depth));
	assign do_pop = pop && (count != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	// Head entry is visible without a pop
	assign dout = mem[rd_ptr];

endmodule

//--- rci_sci_table.sv
// RCI to SCI translation RAM with a registered write stage and a registered read
module rci_sci_table
	import conn_ctx_pkg::*;
(
	input logic clk,

	input logic table_wr,
	input table_wr_t table_data,

	input rci_t raddr,
	output sci_t sci_q
);

	sci_t mem [table_depth];

	logic wr_q;
	table_wr_t data_q;

	// Write is retimed by one stage before it reaches the RAM
	always_ff @(posedge clk) begin
		wr_q <= table_wr;
		data_q <= table_data;
	end

	always_ff @(posedge clk) begin
		if (wr_q)
			mem[data_q.rci] <= data_q.sci;
	end

	// Read of an entry being written returns the old SCI
	always_ff @(posedge clk) begin
		sci_q <= mem[raddr];
	end

endmodule

//--- tb_conn_ctx_mem.sv
// Testbench for the connection-context read path: stimulus, shadow models, assertions, watchdog
module tb_conn_ctx_mem
	import conn_ctx_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_single = 8;
	localparam int n_region = 4;
	localparam int n_contend = 4;
	localparam int n_update = 4;
	localparam int n_mix = 300;
	localparam int num_tests = 2 * ctx_depth + table_depth + n_single + n_region
		+ n_contend * num_pu + n_update + n_mix;
	localparam int watchdog_cycles = num_tests * 40 + 200;
	localparam int ack_latency = 4;
	localparam int host_timeout = 20;
	localparam int idle_timeout = 40;

	typedef struct packed {
		ctx_data_t data;
		int unsigned first_cyc;
		int unsigned last_cyc;
	} exp_rsp_t;

	logic clk = 1'b0;
	logic rst_n;
	logic [num_pu-1:0] io_req;
	io_cmd_t io_cmd [num_pu];
	logic table_wr;
	table_wr_t table_data;
	logic reg_sel;
	reg_req_t reg_req;
	logic reg_ack;
	ctx_data_t reg_rdata;
	logic [num_pu-1:0] io_ack;
	ctx_data_t io_ack_data [num_pu];

	// Shadow copies of the table and the context store
	sci_t tbl_shadow [table_depth];
	ctx_data_t ctx_shadow [ctx_depth];
	exp_rsp_t exp_q [num_pu][$];
	logic [num_pu-1:0] pu_busy;
	ctx_addr_t pu_addr [num_pu];
	pu_id_t ptr_model;
	logic host_open;
	int unsigned cyc = 0;

	conn_ctx_mem i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.io_req(io_req),
		.io_cmd(io_cmd),
		.table_wr(table_wr),
		.table_data(table_data),
		.reg_sel(reg_sel),
		.reg_req(reg_req),
		.reg_ack(reg_ack),
		.reg_rdata(reg_rdata),
		.io_ack(io_ack),
		.io_ack_data(io_ack_data)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	// Never two responses in the same cycle
	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(io_ack))
		else fail_run("more than one io_ack bit high in the same cycle");

	assert property (@(posedge clk) disable iff (!rst_n) reg_ack |=> !reg_ack)
		else fail_run("reg_ack stayed high for more than one cycle");

	for (genvar g = 0; g < num_pu; g++) begin : g_lane
		assert property (@(posedge clk) disable iff (!rst_n)
			!io_ack[g] |-> io_ack_data[g] == '0)
			else fail_run($sformatf("error io_ack_data[%0d] expected %h actual %h",
				g, ctx_data_t'(0), $sampled(io_ack_data[g])));
	end

	// Response monitor on the falling edge where outputs are stable
	always @(negedge clk) begin
		exp_rsp_t e;
		if (rst_n) begin
			if (reg_ack) begin
				assert (host_open)
					else fail_run("reg_ack seen without an outstanding host access");
				host_open = 1'b0;
			end
			for (int i = 0; i < num_pu; i++) begin
				if (io_ack[i]) begin
					assert (exp_q[i].size() != 0)
						else fail_run($sformatf("io_ack on PU %0d without a command", i));
					e = exp_q[i].pop_front();
					assert (io_ack_data[i] == e.data)
						else fail_run($sformatf("error io_ack_data[%0d] expected %h actual %h",
							i, e.data, io_ack_data[i]));
					assert (cyc >= e.first_cyc && cyc <= e.last_cyc)
						else fail_run($sformatf("io_ack on PU %0d in cycle %0d, expected %0d to %0d",
							i, cyc, e.first_cyc, e.last_cyc));
					pu_busy[i] = 1'b0;
				end
			end
		end
	end

	function automatic int pending_reads();
		int n;
		n = 0;
		for (int i = 0; i < num_pu; i++) begin
			n += exp_q[i].size();
		end
		return n;
	endfunction

	// A lane whose ack is showing still counts as busy in that cycle
	function automatic bit addr_in_flight(input ctx_addr_t addr);
		for (int i = 0; i < num_pu; i++) begin
			if ((pu_busy[i] || io_ack[i]) && pu_addr[i] == addr)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic table_write(input rci_t rci, input sci_t sci);
		@(negedge clk);
		table_wr = 1'b1;
		table_data = '{rci: rci, sci: sci};
		tbl_shadow[rci] = sci;
		@(negedge clk);
		table_wr = 1'b0;
	endtask

	task automatic host_access(input logic wr, input ctx_addr_t addr, input ctx_data_t wdata);
		int waited;
		@(negedge clk);
		reg_sel = 1'b1;
		reg_req = '{rd: !wr, wr: wr, addr: addr, wdata: wdata};
		host_open = 1'b1;
		@(negedge clk);
		reg_sel = 1'b0;
		reg_req = '0;
		waited = 0;
		while (!reg_ack) begin
			if (waited == host_timeout)
				fail_run("host access got no reg_ack");
			@(negedge clk);
			waited++;
		end
		if (wr) begin
			ctx_shadow[addr] = wdata;
		end else begin
			assert (reg_rdata == ctx_shadow[addr])
				else fail_run($sformatf("error reg_rdata expected %h actual %h",
					ctx_shadow[addr], reg_rdata));
		end
	endtask

	task automatic send_cmd(input pu_id_t pu, input logic [region_nbits-1:0] region,
		input rci_t rci, input ofs_t ofs, input bit exact);
		exp_rsp_t e;
		ctx_addr_t addr;
		@(negedge clk);
		io_cmd[pu] = '{region: region, rci: rci, ofs: ofs};
		io_req[pu] = 1'b1;
		if (region == region_ctx) begin
			addr = {tbl_shadow[rci], ofs};
			e.data = ctx_shadow[addr];
			e.first_cyc = cyc + ack_latency;
			e.last_cyc = exact ? e.first_cyc : e.first_cyc + num_pu - 1;
			exp_q[pu].push_back(e);
			pu_busy[pu] = 1'b1;
			pu_addr[pu] = addr;
			ptr_model = pu + 1'b1;
		end
		@(negedge clk);
		io_req[pu] = 1'b0;
	endtask

	// All PUs request together and are granted from the pointer one per cycle
	task automatic contend_round();
		exp_rsp_t e;
		ctx_addr_t addr;
		rci_t rci;
		ofs_t ofs;
		pu_id_t slot;
		@(negedge clk);
		for (int i = 0; i < num_pu; i++) begin
			rci = rci_t'($urandom);
			ofs = ofs_t'($urandom);
			addr = {tbl_shadow[rci], ofs};
			slot = pu_id_t'(i) - ptr_model;
			e.data = ctx_shadow[addr];
			e.first_cyc = cyc + ack_latency + slot;
			e.last_cyc = e.first_cyc;
			io_cmd[i] = '{region: region_ctx, rci: rci, ofs: ofs};
			exp_q[i].push_back(e);
			pu_busy[i] = 1'b1;
			pu_addr[i] = addr;
		end
		io_req = '1;
		@(negedge clk);
		io_req = '0;
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (pending_reads() != 0 || io_ack != '0) begin
			if (waited == idle_timeout)
				fail_run("PU responses still missing after the idle timeout");
			@(negedge clk);
			waited++;
		end
		@(negedge clk);
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		fail_run($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
	end

	initial begin
		ctx_addr_t addr;
		rci_t rci;
		sci_t sci;
		pu_id_t pu;
		logic [region_nbits-1:0] region;
		int unsigned pick;
		void'($urandom(24));
		rst_n = 1'b0;
		io_req = '0;
		for (int i = 0; i < num_pu; i++) begin
			io_cmd[i] = '0;
		end
		table_wr = 1'b0;
		table_data = '0;
		reg_sel = 1'b0;
		reg_req = '0;
		pu_busy = '0;
		ptr_model = '0;
		host_open = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		assert (io_ack == '0 && !reg_ack)
			else fail_run("io_ack or reg_ack high after reset");

		// Fill the whole store, then read every word back
		for (int a = 0; a < ctx_depth; a++) begin
			host_access(1'b1, ctx_addr_t'(a), ctx_data_t'($urandom));
		end
		for (int a = 0; a < ctx_depth; a++) begin
			host_access(1'b0, ctx_addr_t'(a), '0);
		end

		for (int r = 0; r < table_depth; r++) begin
			table_write(rci_t'(r), sci_t'($urandom));
		end
		repeat (2) @(negedge clk);

		for (int n = 0; n < n_single; n++) begin
			send_cmd(pu_id_t'($urandom), region_ctx, rci_t'($urandom), ofs_t'($urandom), 1'b1);
			wait_idle();
		end

		for (int n = 0; n < n_region; n++) begin
			region = region_nbits'($urandom);
			if (region == region_ctx)
				region = region + 1'b1;
			send_cmd(pu_id_t'($urandom), region, rci_t'($urandom), ofs_t'($urandom), 1'b1);
			repeat (12) @(negedge clk);
		end

		for (int n = 0; n < n_contend; n++) begin
			contend_round();
			wait_idle();
		end

		// New SCI always differs from the old one
		for (int n = 0; n < n_update; n++) begin
			rci = rci_t'($urandom);
			sci = tbl_shadow[rci] + sci_t'($urandom_range(1, 2 ** sci_nbits - 1));
			table_write(rci, sci);
			repeat (2) @(negedge clk);
			send_cmd(pu_id_t'($urandom), region_ctx, rci, ofs_t'($urandom), 1'b1);
			wait_idle();
		end

		for (int n = 0; n < n_mix; n++) begin
			pick = $urandom_range(0, 3);
			if (pick == 0) begin
				addr = ctx_addr_t'($urandom);
				while (addr_in_flight(addr))
					addr = addr + 1'b1;
				host_access(1'b1, addr, ctx_data_t'($urandom));
			end else if (pick == 1) begin
				host_access(1'b0, ctx_addr_t'($urandom), '0);
			end else begin
				pu = pu_id_t'($urandom);
				region = ($urandom_range(0, 7) == 0) ? region_ctx + 1'b1 : region_ctx;
				if (pu_busy[pu] || io_ack[pu])
					@(negedge clk);
				else
					send_cmd(pu, region, rci_t'($urandom), ofs_t'($urandom), 1'b0);
			end
		end
		wait_idle();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- vlog.f
conn_ctx_pkg.sv
conn_req_arbiter.sv
rci_sci_table.sv
pu_tag_fifo.sv
conn_ctx_store.sv
conn_ctx_mem.sv
tb_conn_ctx_mem.sv
